/* source/sao_pix_pkg.sv */
/*
 * Pixel level widths and types shared by the SAO datapath.
 * Covers the reconstructed window, the 4x4 block, the per-pixel
 * category masks and the block coordinates inside the tree block.
 */

`default_nettype none

package sao_pix_pkg;

    // ------------------------------------------------
    // Geometry
    // ------------------------------------------------
    localparam int PIX_W    = 8;
    localparam int ROW_PIX  = 6;
    localparam int WIN_ROWS = 5;
    localparam int BLK_DIM  = 4;
    localparam int BLK_PIX  = BLK_DIM * BLK_DIM;
    localparam int MASK_W   = BLK_PIX;
    localparam int POS_W    = 4;

    // ------------------------------------------------
    // Vector types
    // ------------------------------------------------
    typedef logic [PIX_W-1:0]           pix_t;
    // Pixel 0 of a row sits in the top bits
    typedef logic [ROW_PIX*PIX_W-1:0]   row_t;
    // One 4-pixel row of the output block
    typedef logic [BLK_DIM*PIX_W-1:0]   brow_t;
    // Block row 0 sits in the top bits
    typedef logic [BLK_PIX*PIX_W-1:0]   blk_t;
    // Bit 15 is the top-left centre pixel
    typedef logic [MASK_W-1:0]          mask_t;
    typedef logic [POS_W-1:0]           pos_t;

endpackage

`default_nettype wire

/* source/sao_ctrl_pkg.sv */
/*
 * SAO control codes and parameter field widths.
 * Type and component codes follow the encoder parameter set;
 * four signed offsets travel packed, category 0 in the low bits.
 */

`default_nettype none

package sao_ctrl_pkg;

    // ------------------------------------------------
    // Field widths
    // ------------------------------------------------
    localparam int TYPE_W = 3;
    localparam int BAND_W = 5;
    localparam int OFF_W  = 3;
    localparam int COMP_W = 2;
    localparam int N_CAT  = 4;

    typedef logic [TYPE_W-1:0]          sao_type_t;
    typedef logic [BAND_W-1:0]          band_t;
    typedef logic signed [OFF_W-1:0]    offset_t;
    typedef logic [N_CAT*OFF_W-1:0]     offsets_t;
    typedef logic [COMP_W-1:0]          comp_sel_t;

    // ------------------------------------------------
    // Codes
    // ------------------------------------------------
    // Types 5..7 apply no offset
    localparam sao_type_t SAO_EO_0   = 3'd0;
    localparam sao_type_t SAO_EO_90  = 3'd1;
    localparam sao_type_t SAO_EO_135 = 3'd2;
    localparam sao_type_t SAO_EO_45  = 3'd3;
    localparam sao_type_t SAO_BO     = 3'd4;

    // Code 3 selects no component
    localparam comp_sel_t COMP_Y = 2'd0;
    localparam comp_sel_t COMP_U = 2'd1;
    localparam comp_sel_t COMP_V = 2'd2;

    localparam int EO_DIRS   = 4;
    localparam int BO_BANDS  = 8;
    localparam int BO_WINDOW = 4;

endpackage

`default_nettype wire

/* source/sao_param_select.sv */
/*
 * Picks the SAO parameters of the active component.
 * Outside the output phase, or with no component selected, it
 * drives type 0 with zero offsets so the block passes unchanged.
 */

`timescale 1ns/10ps
`default_nettype none

module sao_param_select
    import sao_ctrl_pkg::*;
(
    input  wire logic       apply_i,
    input  wire comp_sel_t  comp_sel_i,
    input  wire sao_type_t  y_type_i,
    input  wire sao_type_t  u_type_i,
    input  wire sao_type_t  v_type_i,
    input  wire band_t      y_band_i,
    input  wire band_t      u_band_i,
    input  wire band_t      v_band_i,
    input  wire offsets_t   y_offsets_i,
    input  wire offsets_t   u_offsets_i,
    input  wire offsets_t   v_offsets_i,
    output sao_type_t       sao_type_o,
    output band_t           band_pos_o,
    output offset_t         offset_o [N_CAT]
);

    offsets_t sel_offsets;

    always_comb begin
        sao_type_o  = '0;
        band_pos_o  = '0;
        sel_offsets = '0;
        if (apply_i) begin
            case (comp_sel_i)
                COMP_Y: begin
                    sao_type_o  = y_type_i;
                    band_pos_o  = y_band_i;
                    sel_offsets = y_offsets_i;
                end
                COMP_U: begin
                    sao_type_o  = u_type_i;
                    band_pos_o  = u_band_i;
                    sel_offsets = u_offsets_i;
                end
                COMP_V: begin
                    sao_type_o  = v_type_i;
                    band_pos_o  = v_band_i;
                    sel_offsets = v_offsets_i;
                end
                default: begin
                    sao_type_o  = '0;
                end
            endcase
        end
    end

    // Unpack the 3-bit signed fields
    always_comb begin
        for (int i = 0; i < N_CAT; i++) begin
            offset_o[i] = offset_t'(sel_offsets[i*OFF_W +: OFF_W]);
        end
    end

endmodule

`default_nettype wire

/* source/sao_class_select.sv */
/*
 * Category mask selection.
 * Edge types take the four masks of their direction; the first
 * index of eo_mask_i is the edge type code. Band offset takes a
 * window of four consecutive band masks, placed by band position
 * relative to the band base of the block.
 */

`timescale 1ns/10ps
`default_nettype none

module sao_class_select
    import sao_pix_pkg::*;
    import sao_ctrl_pkg::*;
(
    input  wire sao_type_t  sao_type_i,
    input  wire band_t      band_pos_i,
    input  wire band_t      bo_base_i,
    input  wire mask_t      eo_mask_i [EO_DIRS][N_CAT],
    input  wire mask_t      bo_mask_i [BO_BANDS],
    output mask_t           cat_mask_o [N_CAT]
);

    band_t      band_diff;
    logic [2:0] bo_first;
    logic       bo_hit;

    // Wraps in 5 bits, so a negative difference lands above the window
    assign band_diff = band_pos_i - bo_base_i;
    assign bo_hit    = (band_diff <= band_t'(BO_BANDS - BO_WINDOW));
    assign bo_first  = band_diff[2:0];

    always_comb begin
        for (int i = 0; i < N_CAT; i++) begin
            cat_mask_o[i] = '0;
        end
        case (sao_type_i)
            SAO_EO_0, SAO_EO_90, SAO_EO_135, SAO_EO_45: begin
                for (int i = 0; i < N_CAT; i++) begin
                    cat_mask_o[i] = eo_mask_i[sao_type_i[1:0]][i];
                end
            end
            SAO_BO: begin
                if (bo_hit) begin
                    for (int i = 0; i < N_CAT; i++) begin
                        cat_mask_o[i] = bo_mask_i[bo_first + 3'(i)];
                    end
                end
            end
            default: begin
                // No offset for unused type codes
                cat_mask_o[0] = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/sao_offset_apply.sv */
/*
 * Adds the SAO offset to the 16 centre pixels of the window.
 * Each pixel takes the offset of its first set category, then the
 * sum is clipped to the pixel range.
 */

`timescale 1ns/10ps
`default_nettype none

module sao_offset_apply
    import sao_pix_pkg::*;
    import sao_ctrl_pkg::*;
(
    input  wire mask_t      cat_mask_i [N_CAT],
    input  wire offset_t    offset_i [N_CAT],
    input  wire row_t       rec_row_i [WIN_ROWS],
    output blk_t            pix_o
);

    // Block pixel k and mask bit k refer to the same centre pixel
    for (genvar k = 0; k < BLK_PIX; k++) begin : g_pix
        localparam int WROW = WIN_ROWS - 1 - k / BLK_DIM;
        localparam int WCOL = 1 + k % BLK_DIM;

        offset_t                    off;
        logic signed [PIX_W+1:0]    pix_s;
        logic signed [PIX_W+1:0]    off_s;
        logic signed [PIX_W+1:0]    sum;

        // Category 0 has the highest priority
        always_comb begin
            off = '0;
            for (int c = N_CAT - 1; c >= 0; c--) begin
                if (cat_mask_i[c][k]) begin
                    off = offset_i[c];
                end
            end
        end

        assign pix_s = {2'b00, rec_row_i[WROW][WCOL*PIX_W +: PIX_W]};
        assign off_s = off;
        assign sum   = pix_s + off_s;

        // Clip to 0..255
        assign pix_o[k*PIX_W +: PIX_W] = sum[PIX_W+1] ? '0 :
                                         sum[PIX_W]   ? '1 :
                                                        sum[PIX_W-1:0];
    end

endmodule

`default_nettype wire

/* source/sao_block_assemble.sv */
/*
 * Builds the output block, which lags the processed area by one
 * column. Processed column 4 of each cycle is held for the next
 * block; at the left and top edges of the tree block the raw
 * neighbour pixels are used instead.
 */

`timescale 1ns/10ps
`default_nettype none

module sao_block_assemble
    import sao_pix_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire pos_t   blk_x_i,
    input  wire pos_t   blk_y_i,
    input  wire row_t   rec_row_i [WIN_ROWS],
    input  wire blk_t   pix_i,
    output blk_t        rec_sao_o
);

    pix_t   carry_q [BLK_DIM];
    brow_t  proc_row [BLK_DIM];
    pix_t   left_pix [BLK_DIM];
    brow_t  built_row [BLK_DIM];
    brow_t  out_row [BLK_DIM];
    brow_t  raw_top;
    logic   left_edge;
    logic   top_edge;

    assign left_edge = (blk_x_i == '0);
    assign top_edge  = (blk_y_i == '0);

    // Raw pixels 0..3 of window row 0
    assign raw_top = rec_row_i[0][ROW_PIX*PIX_W-1 -: BLK_DIM*PIX_W];

    // ------------------------------------------------
    // Row building
    // ------------------------------------------------
    for (genvar r = 0; r < BLK_DIM; r++) begin : g_row
        localparam int RW = BLK_DIM * PIX_W;

        assign proc_row[r] = pix_i[(BLK_DIM-1-r)*RW +: RW];

        // Raw column 0 of the same window row at the left edge
        assign left_pix[r] = left_edge ? rec_row_i[r+1][ROW_PIX*PIX_W-1 -: PIX_W]
                                       : carry_q[r];

        // Carried pixel, then processed columns 1..3
        assign built_row[r] = {left_pix[r], proc_row[r][RW-1 -: RW-PIX_W]};

        if (r == 0) begin : g_first
            assign out_row[r] = top_edge ? raw_top : built_row[r];
        end else begin : g_rest
            assign out_row[r] = top_edge ? built_row[r-1] : built_row[r];
        end

        assign rec_sao_o[(BLK_DIM-1-r)*RW +: RW] = out_row[r];
    end

    // ------------------------------------------------
    // Column carry
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < BLK_DIM; r++) begin
                carry_q[r] <= '0;
            end
        end else begin
            // Processed column 4 sits in the low pixel of each row
            for (int r = 0; r < BLK_DIM; r++) begin
                carry_q[r] <= proc_row[r][PIX_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* source/sao_add_offset_top.sv */
/*
 * SAO offset stage, one 4x4 block per clock.
 * Chains parameter select, category select, offset add and block
 * assembly. Only the carried column is registered.
 */

`timescale 1ns/10ps
`default_nettype none

module sao_add_offset_top
    import sao_pix_pkg::*;
    import sao_ctrl_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       apply_i,
    input  wire comp_sel_t  comp_sel_i,
    input  wire pos_t       blk_x_i,
    input  wire pos_t       blk_y_i,
    input  wire band_t      bo_base_i,
    input  wire sao_type_t  y_type_i,
    input  wire band_t      y_band_i,
    input  wire offsets_t   y_offsets_i,
    input  wire sao_type_t  u_type_i,
    input  wire band_t      u_band_i,
    input  wire offsets_t   u_offsets_i,
    input  wire sao_type_t  v_type_i,
    input  wire band_t      v_band_i,
    input  wire offsets_t   v_offsets_i,
    input  wire row_t       rec_row_i [WIN_ROWS],
    input  wire mask_t      eo_mask_i [EO_DIRS][N_CAT],
    input  wire mask_t      bo_mask_i [BO_BANDS],
    output blk_t            rec_sao_o
);

    sao_type_t  sao_type;
    band_t      band_pos;
    offset_t    offsets [N_CAT];
    mask_t      cat_mask [N_CAT];
    blk_t       pix_proc;

    sao_param_select u_param_select (
        .apply_i     (apply_i),
        .comp_sel_i  (comp_sel_i),
        .y_type_i    (y_type_i),
        .u_type_i    (u_type_i),
        .v_type_i    (v_type_i),
        .y_band_i    (y_band_i),
        .u_band_i    (u_band_i),
        .v_band_i    (v_band_i),
        .y_offsets_i (y_offsets_i),
        .u_offsets_i (u_offsets_i),
        .v_offsets_i (v_offsets_i),
        .sao_type_o  (sao_type),
        .band_pos_o  (band_pos),
        .offset_o    (offsets)
    );

    sao_class_select u_class_select (
        .sao_type_i  (sao_type),
        .band_pos_i  (band_pos),
        .bo_base_i   (bo_base_i),
        .eo_mask_i   (eo_mask_i),
        .bo_mask_i   (bo_mask_i),
        .cat_mask_o  (cat_mask)
    );

    sao_offset_apply u_offset_apply (
        .cat_mask_i  (cat_mask),
        .offset_i    (offsets),
        .rec_row_i   (rec_row_i),
        .pix_o       (pix_proc)
    );

    sao_block_assemble u_block_assemble (
        .clk         (clk),
        .rst_n       (rst_n),
        .blk_x_i     (blk_x_i),
        .blk_y_i     (blk_y_i),
        .rec_row_i   (rec_row_i),
        .pix_i       (pix_proc),
        .rec_sao_o   (rec_sao_o)
    );

endmodule

`default_nettype wire

/* sim/sao_asserts.sv */
/*
 * Concurrent checks on the SAO block assembly, bound into it from the
 * testbench. Covers the column carry, the raw left edge and unknown
 * bits on the output block.
 */

`timescale 1ns/10ps
`default_nettype none

module sao_asserts
    import sao_pix_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire pos_t                       blk_x_i,
    input  wire pos_t                       blk_y_i,
    input  wire logic [BLK_DIM*PIX_W-1:0]   carry_i,
    input  wire logic [BLK_DIM*PIX_W-1:0]   col4_i,
    input  wire logic [WIN_ROWS*PIX_W-1:0]  raw_col0_i,
    input  wire blk_t                       rec_sao_i
);

    logic [BLK_DIM*PIX_W-1:0] left_col;

    // Leftmost pixel of each output row, row 0 on top
    always_comb begin
        for (int r = 0; r < BLK_DIM; r++) begin
            left_col[(BLK_DIM-1-r)*PIX_W +: PIX_W] =
                rec_sao_i[(BLK_PIX-1-BLK_DIM*r)*PIX_W +: PIX_W];
        end
    end

    carry_follows: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> carry_i == $past(col4_i))
        else $error("carry registers differ from last processed column 4");

    // Top edge shifts the raw column up by one row
    left_edge_raw: assert property (@(posedge clk) disable iff (!rst_n)
        (blk_x_i == '0) |-> left_col == ((blk_y_i == '0) ? raw_col0_i[39:8]
                                                          : raw_col0_i[31:0]))
        else $error("left output column is not raw column 0 at the left edge");

    out_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(rec_sao_i))
        else $error("output block has unknown bits");

endmodule

`default_nettype wire

/* sim/sao_tb.sv */
/*
 * Directed testbench for the SAO offset stage.
 * Drives one block per cycle and compares each output block with a
 * reference model that keeps its own copy of the carried column.
 */

`timescale 1ns/10ps
`default_nettype none

module sao_tb
    import sao_pix_pkg::*;
    import sao_ctrl_pkg::*;
;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int N_PASS = 11;
    localparam int N_EDGE = 16;
    localparam int N_BAND = 11;
    localparam int N_COMP = 6;
    localparam int N_CLIP = 2;
    localparam int N_POS  = 8;
    localparam int N_BLOCKS = N_PASS + N_EDGE + N_BAND + N_COMP + N_CLIP + N_POS;
    localparam int WATCHDOG_NS = (RESET_CYCLES + N_BLOCKS + 10) * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       apply;
    comp_sel_t  comp_sel;
    pos_t       blk_x;
    pos_t       blk_y;
    band_t      bo_base;
    sao_type_t  comp_type [3];
    band_t      comp_band [3];
    offsets_t   comp_offs [3];
    row_t       rec_row [WIN_ROWS];
    mask_t      eo_mask [EO_DIRS][N_CAT];
    mask_t      bo_mask [BO_BANDS];
    blk_t       rec_sao;
    int         seed = 32'hb241;
    int         model_carry [BLK_DIM];

    always #(CLK_PERIOD / 2) clk = ~clk;

    sao_add_offset_top dut_i (
        .clk (clk), .rst_n (rst_n), .apply_i (apply), .comp_sel_i (comp_sel),
        .blk_x_i (blk_x), .blk_y_i (blk_y), .bo_base_i (bo_base),
        .y_type_i (comp_type[0]), .y_band_i (comp_band[0]), .y_offsets_i (comp_offs[0]),
        .u_type_i (comp_type[1]), .u_band_i (comp_band[1]), .u_offsets_i (comp_offs[1]),
        .v_type_i (comp_type[2]), .v_band_i (comp_band[2]), .v_offsets_i (comp_offs[2]),
        .rec_row_i (rec_row), .eo_mask_i (eo_mask), .bo_mask_i (bo_mask),
        .rec_sao_o (rec_sao)
    );

    bind sao_block_assemble sao_asserts u_asserts (
        .clk        (clk),
        .rst_n      (rst_n),
        .blk_x_i    (blk_x_i),
        .blk_y_i    (blk_y_i),
        .carry_i    ({carry_q[0], carry_q[1], carry_q[2], carry_q[3]}),
        .col4_i     ({proc_row[0][7:0], proc_row[1][7:0], proc_row[2][7:0],
                      proc_row[3][7:0]}),
        .raw_col0_i ({rec_row_i[0][47:40], rec_row_i[1][47:40], rec_row_i[2][47:40],
                      rec_row_i[3][47:40], rec_row_i[4][47:40]}),
        .rec_sao_i  (rec_sao_o)
    );

    // --------------------------------------------------
    // Random stimulus
    // --------------------------------------------------
    function automatic int rand_below(int n);
        int v;
        v = $random(seed);
        return (v & 32'h7fff_ffff) % n;
    endfunction

    function automatic row_t rand_row();
        logic [63:0] v;
        v = {$random(seed), $random(seed)};
        return v[ROW_PIX*PIX_W-1:0];
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    task automatic randomize_window();
        for (int r = 0; r < WIN_ROWS; r++) begin
            rec_row[r] <= rand_row();
        end
        for (int d = 0; d < EO_DIRS; d++) begin
            for (int c = 0; c < N_CAT; c++) begin
                eo_mask[d][c] <= mask_t'(rand_word());
            end
        end
        for (int b = 0; b < BO_BANDS; b++) begin
            bo_mask[b] <= mask_t'(rand_word());
        end
    endtask

    task automatic randomize_params();
        for (int c = 0; c < 3; c++) begin
            comp_type[c] <= sao_type_t'(rand_below(5));
            comp_band[c] <= band_t'(rand_below(32));
            comp_offs[c] <= offsets_t'(rand_word());
        end
        bo_base <= band_t'(rand_below(32));
        blk_x <= pos_t'(rand_below(4));
        blk_y <= pos_t'(rand_below(4));
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic int win_pix(int r, int c);
        return int'(rec_row[r][(ROW_PIX-1-c)*PIX_W +: PIX_W]);
    endfunction

    task automatic run_model(output blk_t exp_blk);
        int     typ;
        int     band;
        int     d;
        int     raw;
        int     off;
        int     k;
        logic   found;
        int     offs [N_CAT];
        mask_t  cats [N_CAT];
        int     proc [BLK_DIM][BLK_DIM];
        int     built [BLK_DIM][BLK_DIM];
        int     outp [BLK_DIM][BLK_DIM];
        typ = 5;
        band = 0;
        exp_blk = '0;
        for (int c = 0; c < N_CAT; c++) begin
            offs[c] = 0;
            cats[c] = '0;
        end
        if (apply && comp_sel != 2'd3) begin
            typ  = int'(comp_type[comp_sel]);
            band = int'(comp_band[comp_sel]);
            for (int c = 0; c < N_CAT; c++) begin
                raw = int'(comp_offs[comp_sel][c*OFF_W +: OFF_W]);
                offs[c] = (raw >= 4) ? raw - 8 : raw;
            end
        end
        if (typ < EO_DIRS) begin
            for (int c = 0; c < N_CAT; c++) cats[c] = eo_mask[typ][c];
        end else if (typ == 4) begin
            d = (band - int'(bo_base)) & 31;
            if (d <= 4) begin
                for (int c = 0; c < N_CAT; c++) cats[c] = bo_mask[d + c];
            end
        end
        // First set category wins, then clip to 0..255
        for (int r = 0; r < BLK_DIM; r++) begin
            for (int c = 0; c < BLK_DIM; c++) begin
                k = BLK_PIX - 1 - BLK_DIM * r - c;
                off = 0;
                found = 1'b0;
                for (int n = 0; n < N_CAT; n++) begin
                    if (!found && cats[n][k]) begin
                        off = offs[n];
                        found = 1'b1;
                    end
                end
                proc[r][c] = win_pix(r + 1, c + 1) + off;
                if (proc[r][c] < 0) proc[r][c] = 0;
                else if (proc[r][c] > 255) proc[r][c] = 255;
            end
        end
        // Output lags by one column
        for (int r = 0; r < BLK_DIM; r++) begin
            built[r][0] = (blk_x == '0) ? win_pix(r + 1, 0) : model_carry[r];
            for (int c = 1; c < BLK_DIM; c++) built[r][c] = proc[r][c-1];
        end
        for (int r = 0; r < BLK_DIM; r++) begin
            for (int c = 0; c < BLK_DIM; c++) begin
                if (blk_y != '0) outp[r][c] = built[r][c];
                else if (r == 0) outp[r][c] = win_pix(0, c);
                else outp[r][c] = built[r-1][c];
                exp_blk[(BLK_PIX-1-BLK_DIM*r-c)*PIX_W +: PIX_W] = pix_t'(outp[r][c]);
            end
            model_carry[r] = proc[r][BLK_DIM-1];
        end
    endtask

    task automatic check_block(input string name);
        blk_t exp_blk;
        @(negedge clk);
        run_model(exp_blk);
        assert (rec_sao === exp_blk) else begin
            $display("ERROR %s: expected %h, actual %h", name, exp_blk, rec_sao);
            $display("** FAIL **");
            $fatal(1, "output block mismatch");
        end
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_pass_through();
        for (int i = 0; i < N_PASS; i++) begin
            @(posedge clk);
            randomize_window();
            randomize_params();
            apply <= (i >= 4);
            comp_sel <= (i >= 4 && i < 8) ? 2'd3 : COMP_Y;
            // Last three blocks use the unused type codes 5..7
            if (i >= 8) comp_type[0] <= sao_type_t'(i - 3);
            check_block("pass_through");
        end
    endtask

    task automatic test_edge_offsets();
        for (int i = 0; i < N_EDGE; i++) begin
            @(posedge clk);
            randomize_window();
            randomize_params();
            apply <= 1'b1;
            comp_sel <= comp_sel_t'(rand_below(3));
            for (int c = 0; c < 3; c++) comp_type[c] <= sao_type_t'(i / 4);
            check_block("edge_offsets");
        end
    endtask

    task automatic test_band_offsets();
        int diffs [N_BAND] = '{0, 1, 2, 3, 4, 5, 6, 7, 12, -1, -4};
        int base;
        for (int i = 0; i < N_BAND; i++) begin
            @(posedge clk);
            randomize_window();
            randomize_params();
            base = rand_below(32);
            apply <= 1'b1;
            comp_sel <= COMP_U;
            bo_base <= band_t'(base);
            comp_type[1] <= SAO_BO;
            comp_band[1] <= band_t'(base + diffs[i]);
            check_block("band_offsets");
        end
    endtask

    task automatic test_component_choice();
        for (int i = 0; i < N_COMP; i++) begin
            @(posedge clk);
            randomize_window();
            randomize_params();
            apply <= 1'b1;
            comp_sel <= comp_sel_t'(i % 3);
            bo_base <= 5'd6;
            comp_type[0] <= SAO_EO_90;
            comp_offs[0] <= 12'h1a3;
            comp_type[1] <= SAO_BO;
            comp_band[1] <= 5'd8;
            comp_offs[1] <= 12'h6c5;
            comp_type[2] <= SAO_EO_45;
            comp_offs[2] <= 12'h2f1;
            check_block("component_choice");
        end
    endtask

    task automatic test_clipping();
        pix_t   vals [4] = '{8'd0, 8'd1, 8'd254, 8'd255};
        row_t   row;
        mask_t  low;
        mask_t  high;
        int     idx;
        for (int i = 0; i < N_CLIP; i++) begin
            @(posedge clk);
            randomize_window();
            randomize_params();
            low = '0;
            high = '0;
            for (int r = 0; r < BLK_DIM; r++) begin
                row = rand_row();
                for (int c = 0; c < BLK_DIM; c++) begin
                    idx = (r + c + i) % 4;
                    row[(ROW_PIX-2-c)*PIX_W +: PIX_W] = vals[idx];
                    if (idx < 2) low[BLK_PIX-1-BLK_DIM*r-c] = 1'b1;
                    else high[BLK_PIX-1-BLK_DIM*r-c] = 1'b1;
                end
                rec_row[r+1] <= row;
            end
            eo_mask[0][0] <= low;
            eo_mask[0][1] <= high;
            eo_mask[0][2] <= '0;
            eo_mask[0][3] <= '0;
            apply <= 1'b1;
            comp_sel <= COMP_V;
            comp_type[2] <= SAO_EO_0;
            // Category 0 is -4, category 1 is +3
            comp_offs[2] <= {3'd0, 3'd0, 3'b011, 3'b100};
            blk_x <= pos_t'(i + 1);
            blk_y <= 4'd1;
            check_block("clipping");
        end
    endtask

    task automatic test_block_positions();
        int xs [N_POS] = '{0, 1, 2, 3, 0, 1, 0, 3};
        int ys [N_POS] = '{0, 0, 0, 0, 1, 1, 2, 3};
        for (int i = 0; i < N_POS; i++) begin
            @(posedge clk);
            randomize_window();
            randomize_params();
            apply <= 1'b1;
            comp_sel <= COMP_Y;
            blk_x <= pos_t'(xs[i]);
            blk_y <= pos_t'(ys[i]);
            check_block("block_positions");
        end
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        rst_n = 1'b0;
        apply = 1'b0;
        comp_sel = COMP_Y;
        blk_x = '0;
        blk_y = '0;
        bo_base = '0;
        for (int c = 0; c < 3; c++) begin
            comp_type[c] = '0;
            comp_band[c] = '0;
            comp_offs[c] = '0;
        end
        for (int r = 0; r < WIN_ROWS; r++) rec_row[r] = '0;
        for (int d = 0; d < EO_DIRS; d++) begin
            for (int c = 0; c < N_CAT; c++) eo_mask[d][c] = '0;
        end
        for (int b = 0; b < BO_BANDS; b++) bo_mask[b] = '0;
        for (int r = 0; r < BLK_DIM; r++) model_carry[r] = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_pass_through();
        test_edge_offsets();
        test_band_offsets();
        test_component_choice();
        test_clipping();
        test_block_positions();
        @(posedge clk);
        $display("** PASS **");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("** FAIL **");
        $fatal(1, "simulation timeout");
    end

endmodule

`default_nettype wire

/* list.f */
source/sao_pix_pkg.sv
source/sao_ctrl_pkg.sv
source/sao_param_select.sv
source/sao_class_select.sv
source/sao_offset_apply.sv
source/sao_block_assemble.sv
source/sao_add_offset_top.sv
sim/sao_asserts.sv
sim/sao_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the SAO testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sao_tb -f list.f

# The pipe keeps set -e from stopping here, the log decides the result
./obj_dir/Vsao_tb 2>&1 | tee sim.log

if grep -q '\*\* PASS \*\*' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
